/* rtl/ac97_frame_pkg.sv */
package ac97_frame_pkg;

  //////////////////////////////
  // frame geometry
  //////////////////////////////

  localparam int frame_bits = 256;

  typedef logic [$clog2(frame_bits)-1:0] bit_index_t;

  localparam bit_index_t frame_last_bit = bit_index_t'(frame_bits - 1);

  // last bit index of each slot, tag slot first
  localparam bit_index_t slot0_last = bit_index_t'(15);
  localparam bit_index_t slot1_last = bit_index_t'(35);
  localparam bit_index_t slot2_last = bit_index_t'(55);
  localparam bit_index_t slot3_last = bit_index_t'(75);
  localparam bit_index_t slot4_last = bit_index_t'(95);

  // user side ready level, high for about half a frame
  localparam bit_index_t ready_rise_bit = bit_index_t'(128);
  localparam bit_index_t ready_fall_bit = bit_index_t'(2);

  // input slot 3 arrives one bit late, sampled on the falling edge
  localparam bit_index_t left_capture_first = bit_index_t'(slot2_last + 2);
  localparam bit_index_t left_capture_last = bit_index_t'(slot3_last + 1);

  //////////////////////////////
  // slot payloads
  //////////////////////////////

  localparam int slot_width = 20;
  localparam int sample_width = 18;

  typedef logic [slot_width-1:0] slot_t;
  typedef logic [sample_width-1:0] sample_t;

  // valid tags of one frame, latched at the frame boundary
  typedef struct packed {
    logic command_valid;
    logic left_valid;
    logic right_valid;
  } frame_tags_t;

endpackage

/* rtl/codec_ctrl_pkg.sv */
package codec_ctrl_pkg;

  typedef logic [4:0] volume_t;
  typedef logic [7:0] reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // one register access toward the codec
  typedef struct packed {
    reg_addr_t address;
    reg_data_t data;
    logic valid;
  } codec_command_t;

  //////////////////////////////
  // codec register map
  //////////////////////////////

  // bit 7 set means a read
  localparam reg_addr_t reg_read_id = 8'h80;
  localparam reg_addr_t reg_headphone_vol = 8'h04;
  localparam reg_addr_t reg_pcm_vol = 8'h18;
  localparam reg_addr_t reg_record_select = 8'h1A;
  localparam reg_addr_t reg_record_gain = 8'h1C;
  localparam reg_addr_t reg_mic_gain = 8'h0E;
  localparam reg_addr_t reg_beep_vol = 8'h0A;
  localparam reg_addr_t reg_general_purpose = 8'h20;

  // fixed register contents
  localparam reg_data_t read_id_data = 16'h0000;
  localparam reg_data_t pcm_vol_data = 16'h0808;
  // record gain at max on both sides
  localparam reg_data_t record_gain_data = 16'h0F0F;
  // +20 dB mic boost
  localparam reg_data_t mic_gain_data = 16'h8048;
  localparam reg_data_t beep_vol_data = 16'h0000;
  // pcm out bypasses mix1
  localparam reg_data_t general_purpose_data = 16'h8000;

  localparam logic [2:0] source_mic = 3'd0;

  //////////////////////////////
  // user controls and timing
  //////////////////////////////

  localparam volume_t volume_max = 5'd31;
  localparam volume_t volume_reset = 5'd13;

  // about 10 ms at 27 MHz
  localparam int debounce_cycles_default = 270000;
  localparam int codec_reset_delay = 1023;

endpackage

/* rtl/debounce.sv */
`timescale 1ns/10ps

module debounce import codec_ctrl_pkg::*; #(
  parameter int settle_cycles = debounce_cycles_default
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  typedef logic [$clog2(settle_cycles + 1)-1:0] count_t;

  count_t count;
  logic last_noisy;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      count <= '0;
      last_noisy <= noisy;
      clean <= noisy;
    end else if (noisy != last_noisy) begin
      // input moved, start settling again
      last_noisy <= noisy;
      count <= '0;
    end else if (count == count_t'(settle_cycles)) begin
      // stable long enough
      clean <= last_noisy;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

/* rtl/volume_control.sv */
`timescale 1ns/10ps

module volume_control import codec_ctrl_pkg::*; #(
  parameter int settle_cycles = debounce_cycles_default
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic button_up,
  input  logic button_down,
  output volume_t volume
);

  logic up_clean;
  logic down_clean;
  logic up_prev;
  logic down_prev;
  logic up_edge;
  logic down_edge;

  debounce #(.settle_cycles(settle_cycles)) debounce_up_i (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .noisy(button_up),
    .clean(up_clean)
  );

  debounce #(.settle_cycles(settle_cycles)) debounce_down_i (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .noisy(button_down),
    .clean(down_clean)
  );

  assign up_edge = up_clean & ~up_prev;
  assign down_edge = down_clean & ~down_prev;

  always_ff @(posedge clock_27mhz) begin
    // prev tracks clean even in reset, so a held button gives no edge
    up_prev <= up_clean;
    down_prev <= down_clean;
    if (reset) begin
      volume <= volume_reset;
    end else begin
      if (up_edge && volume != volume_max) begin
        volume <= volume + 1'b1;
      end
      // down is evaluated last and wins a tie
      if (down_edge && volume != '0) begin
        volume <= volume - 1'b1;
      end
    end
  end

endmodule

/* rtl/codec_command_sequencer.sv */
`timescale 1ns/10ps

module codec_command_sequencer import codec_ctrl_pkg::*; (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic ready,
  input  volume_t volume,
  output codec_command_t command
);

  logic [3:0] state;
  logic command_valid;
  reg_addr_t command_address;
  reg_data_t command_data;
  volume_t attenuation;

  // codec takes attenuation, 0 is loudest
  assign attenuation = volume_max - volume;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      state <= '0;
      command_valid <= 1'b0;
    end else begin
      if (ready) begin
        state <= state + 1'b1;
      end
      if (state == 4'd0) begin
        command_valid <= 1'b1;
      end
    end
  end

  // one register access per frame, the list repeats every 16 frames
  always_ff @(posedge clock_27mhz) begin
    case (state)
      4'd3: begin
        command_address <= reg_headphone_vol;
        command_data <= {3'b000, attenuation, 3'b000, attenuation};
      end
      4'd5: begin
        command_address <= reg_pcm_vol;
        command_data <= pcm_vol_data;
      end
      4'd6: begin
        command_address <= reg_record_select;
        command_data <= {5'b00000, source_mic, 5'b00000, source_mic};
      end
      4'd7: begin
        command_address <= reg_record_gain;
        command_data <= record_gain_data;
      end
      4'd9: begin
        command_address <= reg_mic_gain;
        command_data <= mic_gain_data;
      end
      4'd10: begin
        command_address <= reg_beep_vol;
        command_data <= beep_vol_data;
      end
      4'd11: begin
        command_address <= reg_general_purpose;
        command_data <= general_purpose_data;
      end
      // states 0 and 1 and the gaps read the id
      default: begin
        command_address <= reg_read_id;
        command_data <= read_id_data;
      end
    endcase
  end

  assign command = '{address: command_address, data: command_data, valid: command_valid};

endmodule

/* rtl/ac97_frame_engine.sv */
`timescale 1ns/10ps

module ac97_frame_engine import ac97_frame_pkg::*, codec_ctrl_pkg::*; (
  input  logic ac97_bit_clock,
  input  logic reset,
  input  codec_command_t command,
  input  sample_t out_sample,
  output sample_t left_in,
  output logic frame_ready,
  output logic ac97_synch,
  output logic ac97_sdata_out,
  input  logic ac97_sdata_in
);

  logic reset_meta;
  logic reset_bit;
  bit_index_t bit_count;
  frame_tags_t tags;
  reg_addr_t cmd_address_q;
  reg_data_t cmd_data_q;
  sample_t sample_q;
  slot_t out_slot;
  slot_t tx_shift;
  slot_t rx_shift;

  // reset comes from the 27 MHz side
  always_ff @(posedge ac97_bit_clock) begin
    reset_meta <= reset;
    reset_bit <= reset_meta;
  end

  //////////////////////////////
  // frame timing
  //////////////////////////////

  always_ff @(posedge ac97_bit_clock) begin
    if (reset_bit) begin
      bit_count <= '0;
      ac97_synch <= 1'b0;
      frame_ready <= 1'b0;
      tags <= '0;
    end else begin
      bit_count <= bit_count + 1'b1;
      if (bit_count == frame_last_bit) begin
        ac97_synch <= 1'b1;
        tags <= '{command_valid: command.valid, left_valid: 1'b1, right_valid: 1'b1};
      end else if (bit_count == slot0_last) begin
        ac97_synch <= 1'b0;
      end
      if (bit_count == ready_rise_bit) begin
        frame_ready <= 1'b1;
      end else if (bit_count == ready_fall_bit) begin
        frame_ready <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // outgoing slots
  //////////////////////////////

  // mono, so both channels carry the same sample
  assign out_slot = {sample_q, {(slot_width - sample_width){1'b0}}};

  always_ff @(posedge ac97_bit_clock) begin
    if (bit_count == frame_last_bit) begin
      cmd_address_q <= command.address;
      cmd_data_q <= command.data;
      sample_q <= out_sample;
    end
    // reload as each slot ends, otherwise shift msb first
    case (bit_count)
      slot0_last: tx_shift <= tags.command_valid ? {cmd_address_q, 12'h000} : '0;
      slot1_last: tx_shift <= tags.command_valid ? {cmd_data_q, 4'h0} : '0;
      slot2_last: tx_shift <= tags.left_valid ? out_slot : '0;
      slot3_last: tx_shift <= tags.right_valid ? out_slot : '0;
      default: tx_shift <= {tx_shift[slot_width-2:0], 1'b0};
    endcase
  end

  always_ff @(posedge ac97_bit_clock) begin
    if (reset_bit) begin
      ac97_sdata_out <= 1'b0;
    end else if (bit_count <= slot0_last) begin
      // tag slot
      case (bit_count[3:0])
        4'd0: ac97_sdata_out <= 1'b1;
        4'd1, 4'd2: ac97_sdata_out <= tags.command_valid;
        4'd3: ac97_sdata_out <= tags.left_valid;
        4'd4: ac97_sdata_out <= tags.right_valid;
        default: ac97_sdata_out <= 1'b0;
      endcase
    end else if (bit_count <= slot4_last) begin
      ac97_sdata_out <= tx_shift[slot_width-1];
    end else begin
      ac97_sdata_out <= 1'b0;
    end
  end

  //////////////////////////////
  // incoming left slot
  //////////////////////////////

  always_ff @(negedge ac97_bit_clock) begin
    if (bit_count >= left_capture_first && bit_count <= left_capture_last) begin
      rx_shift <= {rx_shift[slot_width-2:0], ac97_sdata_in};
    end
  end

  // drop the two lsbs
  assign left_in = rx_shift[slot_width-1 -: sample_width];

endmodule

/* rtl/ac97_volume_link.sv */
`timescale 1ns/10ps

module ac97_volume_link import ac97_frame_pkg::*, codec_ctrl_pkg::*; #(
  parameter int debounce_cycles = debounce_cycles_default
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic button_up,
  input  logic button_down,
  input  sample_t audio_out_data,
  output sample_t audio_in_data,
  output logic ready,
  output volume_t volume,
  output logic audio_reset_b,
  output logic ac97_sdata_out,
  output logic ac97_synch,
  input  logic ac97_bit_clock,
  input  logic ac97_sdata_in
);

  typedef logic [$clog2(codec_reset_delay + 1)-1:0] reset_count_t;

  reset_count_t reset_count;
  logic [2:0] ready_sync;
  logic frame_ready;
  sample_t out_sample;
  codec_command_t command;

  // hold the codec in reset a while after our own reset
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      audio_reset_b <= 1'b0;
      reset_count <= '0;
    end else if (reset_count == reset_count_t'(codec_reset_delay)) begin
      audio_reset_b <= 1'b1;
    end else begin
      reset_count <= reset_count + 1'b1;
    end
  end

  // frame_ready lives on the bit clock
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      ready_sync <= '0;
    end else begin
      ready_sync <= {ready_sync[1:0], frame_ready};
    end
  end

  assign ready = ready_sync[1] & ~ready_sync[2];

  // held for the whole next frame
  always_ff @(posedge clock_27mhz) begin
    if (ready) begin
      out_sample <= audio_out_data;
    end
  end

  volume_control #(.settle_cycles(debounce_cycles)) volume_control_i (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .volume(volume)
  );

  codec_command_sequencer codec_command_sequencer_i (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .ready(ready),
    .volume(volume),
    .command(command)
  );

  ac97_frame_engine ac97_frame_engine_i (
    .ac97_bit_clock(ac97_bit_clock),
    .reset(reset),
    .command(command),
    .out_sample(out_sample),
    .left_in(audio_in_data),
    .frame_ready(frame_ready),
    .ac97_synch(ac97_synch),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_sdata_in(ac97_sdata_in)
  );

endmodule

/* test/tb_ac97_volume_link.sv */
`timescale 1ns/10ps

module tb_ac97_volume_link import ac97_frame_pkg::*, codec_ctrl_pkg::*; ();

  localparam int debounce_test = 64;
  localparam int press_count = 64;
  localparam int playback_values = 6;
  localparam int ready_wait_limit = 2000;
  localparam longint frame_ns = 256 * 82;
  // reset release, presses, playback frames and a margin
  localparam longint watchdog_ns = 1100 * 20 + press_count * (2 * (80 + 63) + 8) * 20
    + (playback_values * 4 + 12) * frame_ns;

  logic clock_27mhz = 1'b0;
  logic ac97_bit_clock = 1'b0;
  logic reset = 1'b1;
  logic button_up = 1'b0;
  logic button_down = 1'b0;
  sample_t audio_out_data = '0;
  logic ac97_sdata_in = 1'b0;
  sample_t audio_in_data;
  logic ready;
  volume_t volume;
  logic audio_reset_b;
  logic ac97_sdata_out;
  logic ac97_synch;

  int errors = 0;
  int checks = 0;
  logic [15:0] lfsr_state = 16'd18154;

  // codec model state
  logic framing = 1'b0;
  logic prev_synch = 1'b0;
  int bit_pos = 0;
  int high_len = 0;
  int low_len = 0;
  int frame_index = 0;
  logic [95:0] rx_bits = '0;
  // controller output before the first sync
  logic [255:0] boot_bits = '0;
  slot_t last_slot3 = '0;
  slot_t last_slot4 = '0;
  slot_t left_next = '0;
  slot_t left_sent = '0;
  logic left_sent_valid = 1'b0;

  // volume model and the value a press in flight moves to
  volume_t vol_model = 5'd13;
  volume_t vol_pending = 5'd13;
  // model volume when the current frame was latched
  volume_t frame_vol_model = 5'd13;
  volume_t frame_vol_pending = 5'd13;

  ac97_volume_link #(.debounce_cycles(debounce_test)) dut_i (
    .clock_27mhz(clock_27mhz),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .audio_out_data(audio_out_data),
    .audio_in_data(audio_in_data),
    .ready(ready),
    .volume(volume),
    .audio_reset_b(audio_reset_b),
    .ac97_sdata_out(ac97_sdata_out),
    .ac97_synch(ac97_synch),
    .ac97_bit_clock(ac97_bit_clock),
    .ac97_sdata_in(ac97_sdata_in)
  );

  always #10 clock_27mhz = ~clock_27mhz;
  always #41 ac97_bit_clock = ~ac97_bit_clock;

  //////////////////////////////
  // helpers
  //////////////////////////////

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] result;
    result = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      result = {result[30:0], lfsr_state[0]};
    end
    return result;
  endfunction

  function automatic logic [7:0] expected_address(input logic [3:0] state);
    case (state)
      4'd3: return 8'h04;
      4'd5: return 8'h18;
      4'd6: return 8'h1A;
      4'd7: return 8'h1C;
      4'd9: return 8'h0E;
      4'd10: return 8'h0A;
      4'd11: return 8'h20;
      default: return 8'h80;
    endcase
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    errors++;
    $display("Fail %s: got 0x%h expected 0x%h", name, got, expected);
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    do begin
      @(posedge clock_27mhz);
      #1;
      waited++;
    end while (!ready && waited < ready_wait_limit);
    assert (ready) else begin
      errors++;
      $display("no ready pulse arrived within %0d clock cycles", ready_wait_limit);
    end
  endtask

  task automatic set_buttons(input logic up, input logic down);
    @(posedge clock_27mhz);
    #2;
    button_up = up;
    button_down = down;
  endtask

  //////////////////////////////
  // codec side of the link
  //////////////////////////////

  task automatic check_frame();
    logic [15:0] tag;
    slot_t slot1;
    slot_t slot2;
    logic [7:0] addr_exp;
    volume_t att_a;
    volume_t att_b;
    tag = rx_bits[95:80];
    slot1 = rx_bits[79:60];
    slot2 = rx_bits[59:40];
    frame_index++;
    checks += 2;
    // frame valid, command valid twice, left and right valid
    assert (tag == 16'hF800) else report_value("slot0 tags", 32'(tag), 32'h0000F800);
    addr_exp = expected_address(4'(frame_index));
    assert (slot1[19:12] == addr_exp) else
      report_value("slot1 command address", 32'(slot1[19:12]), 32'(addr_exp));
    if (addr_exp == 8'h04) begin
      att_a = slot2[16:12];
      att_b = slot2[8:4];
      checks++;
      assert ((att_a == 5'd31 - frame_vol_model || att_a == 5'd31 - frame_vol_pending)
              && att_b == att_a)
      else report_value("headphone attenuation", 32'({att_a, att_b}),
                        32'({5'd31 - frame_vol_model, 5'd31 - frame_vol_model}));
    end
    last_slot3 = rx_bits[39:20];
    last_slot4 = rx_bits[19:0];
  endtask

  always @(negedge ac97_bit_clock) begin
    if (ac97_synch && !prev_synch) begin
      if (framing) begin
        checks++;
        assert (high_len == 16 && low_len == 240) else begin
          errors++;
          $display("sync had %0d high and %0d low bit clocks", high_len, low_len);
        end
      end else begin
        // frame after reset has no sync, its tag bit 0 lies 255 samples back
        checks++;
        assert (boot_bits[254:239] == 16'h8000) else
          report_value("first frame slot0 tags", 32'(boot_bits[254:239]), 32'h00008000);
      end
      framing = 1'b1;
      bit_pos = 0;
      high_len = 1;
      low_len = 0;
      frame_vol_model = vol_model;
      frame_vol_pending = vol_pending;
    end else if (framing) begin
      bit_pos++;
      if (ac97_synch) begin
        high_len++;
      end else begin
        low_len++;
      end
    end else begin
      boot_bits = {boot_bits[254:0], ac97_sdata_out};
    end
    prev_synch = ac97_synch;
    if (framing) begin
      // controller data lags sync by one bit
      if (bit_pos >= 1 && bit_pos <= 96) begin
        rx_bits = {rx_bits[94:0], ac97_sdata_out};
      end
      if (bit_pos == 97) begin
        check_frame();
      end
      if (bit_pos == 56) begin
        left_next = slot_t'(random_bits(20));
      end
      // one bit ahead of the falling edge that samples it
      if (bit_pos >= 56 && bit_pos <= 75) begin
        ac97_sdata_in <= left_next[5'(75 - bit_pos)];
      end else begin
        ac97_sdata_in <= 1'b0;
      end
      if (bit_pos == 77) begin
        left_sent = left_next;
        left_sent_valid = 1'b1;
      end
    end
  end

  // capture path checked on every ready pulse
  always @(posedge clock_27mhz) begin
    #1;
    if (ready && left_sent_valid) begin
      checks++;
      assert (audio_in_data == left_sent[19:2]) else
        report_value("audio_in_data", 32'(audio_in_data), 32'(left_sent[19:2]));
    end
  end

  //////////////////////////////
  // test phases
  //////////////////////////////

  task automatic check_reset_release();
    checks += 2;
    assert (audio_reset_b == 1'b0) else report_value("audio_reset_b", 32'(audio_reset_b), 32'h0);
    assert (volume == 5'd13) else report_value("volume", 32'(volume), 32'd13);
    for (int i = 1; i <= 1024; i++) begin
      @(posedge clock_27mhz);
      #1;
      checks++;
      assert (audio_reset_b == (i == 1024)) else
        report_value("audio_reset_b", 32'(audio_reset_b), 32'(i == 1024));
    end
  endtask

  task automatic run_presses();
    logic go_up;
    int hold;
    for (int n = 0; n < press_count; n++) begin
      // mostly up first, then mostly down
      if (n < press_count / 2) begin
        go_up = (random_bits(2) != 32'd0);
      end else begin
        go_up = (random_bits(2) == 32'd0);
      end
      if (go_up) begin
        vol_pending = (vol_model == 5'd31) ? vol_model : vol_model + 5'd1;
      end else begin
        vol_pending = (vol_model == 5'd0) ? vol_model : vol_model - 5'd1;
      end
      hold = 80 + int'(random_bits(6));
      set_buttons(go_up, !go_up);
      repeat (hold) @(posedge clock_27mhz);
      hold = 80 + int'(random_bits(6));
      set_buttons(1'b0, 1'b0);
      repeat (hold) @(posedge clock_27mhz);
      #1;
      checks++;
      assert (volume == vol_pending) else report_value("volume", 32'(volume), 32'(vol_pending));
      vol_model = vol_pending;
    end
  endtask

  task automatic run_playback();
    sample_t value;
    for (int n = 0; n < playback_values; n++) begin
      value = sample_t'(random_bits(18));
      wait_ready();
      #1;
      audio_out_data = value;
      repeat (3) wait_ready();
      checks += 2;
      assert (last_slot3 == {value, 2'b00}) else
        report_value("slot3 pcm left", 32'(last_slot3), 32'({value, 2'b00}));
      assert (last_slot4 == {value, 2'b00}) else
        report_value("slot4 pcm right", 32'(last_slot4), 32'({value, 2'b00}));
    end
  endtask

  initial begin
    repeat (4) @(posedge clock_27mhz);
    #2;
    reset = 1'b0;
    check_reset_release();
    run_presses();
    run_playback();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* ac97_volume_link.f */
rtl/ac97_frame_pkg.sv
rtl/codec_ctrl_pkg.sv
rtl/debounce.sv
rtl/volume_control.sv
rtl/codec_command_sequencer.sv
rtl/ac97_frame_engine.sv
rtl/ac97_volume_link.sv
test/tb_ac97_volume_link.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AC97 volume link testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
  --top-module tb_ac97_volume_link \
  -f ac97_volume_link.f \
  --Mdir obj_dir \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
